// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_game_video
RTL_TOP   ?= game_video
FILELIST  ?= game_video.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --assert
LINTFLAGS ?= --lint-only

RTL_SRCS  ?= logic/video_pkg.sv logic/video_timer.sv logic/tile_rom.sv \
             logic/char_layer.sv logic/col_mix.sv logic/game_video.sv
TB_SRCS   ?= tb/tb_game_video.sv include/tb_helpers.svh

SIM_BIN = $(BUILD_DIR)/V$(TOP)

.PHONY: all build run lint clean

all: run

build: $(SIM_BIN)

$(SIM_BIN): $(FILELIST) $(RTL_SRCS) $(TB_SRCS)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)

run: $(SIM_BIN)
	./$(SIM_BIN)

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(RTL_TOP) $(RTL_SRCS)

clean:
	rm -rf $(BUILD_DIR)

// File: game_video.f
+incdir+include
logic/video_pkg.sv
logic/video_timer.sv
logic/tile_rom.sv
logic/char_layer.sv
logic/col_mix.sv
logic/game_video.sv
tb/tb_game_video.sv

// File: logic/char_layer.sv
`timescale 1ns/1ns

module char_layer (
	input  logic                              clk,
	input  logic                              rst,
	input  logic [video_pkg::CNT_W-1:0]       h,
	input  logic [video_pkg::CNT_W-1:0]       v,
	input  logic                              lhbl,
	input  logic                              lvbl,
	input  logic [video_pkg::CPU_AW-1:0]      cpu_addr,
	input  logic [video_pkg::CPU_DW-1:0]      cpu_dout,
	input  logic                              cpu_we,
	input  logic [video_pkg::ROM_AW-1:0]      romload_addr,
	input  logic [7:0]                        romload_data,
	input  logic                              romload_wr,
	output logic [video_pkg::COL_W-1:0]       char_col,
	output logic [video_pkg::PAL_W-1:0]       char_pal,
	output logic                              lhbl_d,
	output logic                              lvbl_d
);
	import video_pkg::*;

	localparam int MAP_N = 2**REGION_AW;

	logic [CPU_DW-1:0]      tile_map [MAP_N];
	logic [REGION_AW-1:0]   map_idx;
	logic                   map_wr;

	// Stage 1 outputs
	logic [CPU_DW-1:0]      map_q;
	logic [2:0]             row1;
	logic [2:0]             pix1;

	// Stage 2 outputs
	logic [ROM_AW-2:0]      rom_addr;
	logic [15:0]            rom_word;
	logic [PAL_W-1:0]       pal2;
	logic [2:0]             pix2;

	logic [CHAR_LAT-1:0]    hbl_sr;
	logic [CHAR_LAT-1:0]    vbl_sr;

	assign map_idx = {v[5:3], h[5:3]};   // 8x8 tile map
	assign map_wr  = cpu_we && (cpu_region(cpu_addr) == REG_TILEMAP);

	// Stage 1, tile map read and CPU writes
	always_ff @(posedge clk) begin
		if (map_wr)
			tile_map[cpu_addr[REGION_AW-1:0]] <= cpu_dout;
		map_q <= tile_map[map_idx];
		row1  <= v[2:0];
		pix1  <= h[2:0];
	end

	// Stage 2, graphics row fetch
	assign rom_addr = {map_q[CPU_DW-1 -: TILE_CODE_W], row1};

	tile_rom u_tile_rom (
		.clk        ( clk          ),
		.load_addr  ( romload_addr ),
		.load_data  ( romload_data ),
		.load_wr    ( romload_wr   ),
		.fetch_addr ( rom_addr     ),
		.fetch_data ( rom_word     )
	);

	always_ff @(posedge clk) begin
		pal2 <= map_q[PAL_W-1:0];
		pix2 <= pix1;
	end

	// Stage 3, two bits per pixel, pixel 0 in the LSBs
	always_ff @(posedge clk) begin
		char_col <= rom_word[{pix2, 1'b0} +: COL_W];
		char_pal <= pal2;
	end

	// Blanking follows the pixel through all three stages
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			hbl_sr <= '0;
			vbl_sr <= '0;
		end else begin
			hbl_sr <= {hbl_sr[CHAR_LAT-2:0], lhbl};
			vbl_sr <= {vbl_sr[CHAR_LAT-2:0], lvbl};
		end
	end

	assign lhbl_d = hbl_sr[CHAR_LAT-1];
	assign lvbl_d = vbl_sr[CHAR_LAT-1];

endmodule

// File: logic/col_mix.sv
`timescale 1ns/1ns

module col_mix (
	input  logic                          clk,
	input  logic                          rst,
	input  logic [video_pkg::COL_W-1:0]   char_col,
	input  logic [video_pkg::PAL_W-1:0]   char_pal,
	input  logic                          lhbl_d,
	input  logic                          lvbl_d,
	input  logic                          downloading,
	input  logic [video_pkg::CPU_AW-1:0]  cpu_addr,
	input  logic [video_pkg::CPU_DW-1:0]  cpu_dout,
	input  logic                          cpu_we,
	output logic [video_pkg::RGB_W-1:0]   red,
	output logic [video_pkg::RGB_W-1:0]   green,
	output logic [video_pkg::RGB_W-1:0]   blue,
	output logic                          lhbl_out,
	output logic                          lvbl_out
);
	import video_pkg::*;

	localparam int PAL_AW = PAL_W + COL_W;
	localparam int PAL_N  = 2**PAL_AW;

	logic [2*RGB_W-1:0] pal_rg [PAL_N];   // Red high nibble, green low
	logic [RGB_W-1:0]   pal_b  [PAL_N];
	logic [PAL_AW-1:0]  pal_idx;
	logic [PAL_AW-1:0]  wr_idx;
	bus_region_e        wr_region;
	logic               show;

	assign pal_idx   = {char_pal, char_col};
	assign wr_idx    = cpu_addr[PAL_AW-1:0];
	assign wr_region = cpu_region(cpu_addr);

	// Video is muted outside the visible area and while ROMs load
	assign show = lhbl_d && lvbl_d && !downloading;

	always_ff @(posedge clk) begin
		if (cpu_we && wr_region == REG_PAL_RG)
			pal_rg[wr_idx] <= cpu_dout;
		if (cpu_we && wr_region == REG_PAL_B)
			pal_b[wr_idx] <= cpu_dout[RGB_W-1:0];
	end

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			red      <= '0;
			green    <= '0;
			blue     <= '0;
			lhbl_out <= 1'b0;
			lvbl_out <= 1'b0;
		end else begin
			lhbl_out <= lhbl_d;   // Kept aligned with RGB
			lvbl_out <= lvbl_d;
			if (show) begin
				red   <= pal_rg[pal_idx][2*RGB_W-1:RGB_W];
				green <= pal_rg[pal_idx][RGB_W-1:0];
				blue  <= pal_b[pal_idx];
			end else begin
				red   <= '0;
				green <= '0;
				blue  <= '0;
			end
		end
	end

endmodule

// File: logic/game_video.sv
`timescale 1ns/1ns

module game_video #(
	parameter int H_TOTAL   = 64,
	parameter int H_VISIBLE = 48,
	parameter int V_TOTAL   = 40,
	parameter int V_VISIBLE = 32
) (
	input  logic                          clk,
	input  logic                          rst,
	input  logic                          downloading,
	input  logic [video_pkg::CPU_AW-1:0]  cpu_addr,
	input  logic [video_pkg::CPU_DW-1:0]  cpu_dout,
	input  logic                          cpu_we,
	input  logic [video_pkg::ROM_AW-1:0]  romload_addr,
	input  logic [7:0]                    romload_data,
	input  logic                          romload_wr,
	output logic [video_pkg::RGB_W-1:0]   red,
	output logic [video_pkg::RGB_W-1:0]   green,
	output logic [video_pkg::RGB_W-1:0]   blue,
	output logic                          lhbl,
	output logic                          lvbl
);
	import video_pkg::*;

	// Raster position from the timer
	logic [CNT_W-1:0] h;
	logic [CNT_W-1:0] v;
	logic             raw_lhbl;
	logic             raw_lvbl;

	// Character layer output, CHAR_LAT cycles behind the timer
	logic [COL_W-1:0] char_col;
	logic [PAL_W-1:0] char_pal;
	logic             char_lhbl;
	logic             char_lvbl;

	video_timer #(
		.H_TOTAL   ( H_TOTAL   ),
		.H_VISIBLE ( H_VISIBLE ),
		.V_TOTAL   ( V_TOTAL   ),
		.V_VISIBLE ( V_VISIBLE )
	) u_timer (
		.clk  ( clk      ),
		.rst  ( rst      ),
		.h    ( h        ),
		.v    ( v        ),
		.lhbl ( raw_lhbl ),
		.lvbl ( raw_lvbl )
	);

	char_layer u_char (
		.clk          ( clk          ),
		.rst          ( rst          ),
		.h            ( h            ),
		.v            ( v            ),
		.lhbl         ( raw_lhbl     ),
		.lvbl         ( raw_lvbl     ),
		.cpu_addr     ( cpu_addr     ),
		.cpu_dout     ( cpu_dout     ),
		.cpu_we       ( cpu_we       ),
		.romload_addr ( romload_addr ),
		.romload_data ( romload_data ),
		.romload_wr   ( romload_wr   ),
		.char_col     ( char_col     ),
		.char_pal     ( char_pal     ),
		.lhbl_d       ( char_lhbl    ),
		.lvbl_d       ( char_lvbl    )
	);

	col_mix u_colmix (
		.clk         ( clk         ),
		.rst         ( rst         ),
		.char_col    ( char_col    ),
		.char_pal    ( char_pal    ),
		.lhbl_d      ( char_lhbl   ),
		.lvbl_d      ( char_lvbl   ),
		.downloading ( downloading ),
		.cpu_addr    ( cpu_addr    ),
		.cpu_dout    ( cpu_dout    ),
		.cpu_we      ( cpu_we      ),
		.red         ( red         ),
		.green       ( green       ),
		.blue        ( blue        ),
		.lhbl_out    ( lhbl        ),
		.lvbl_out    ( lvbl        )
	);

endmodule

// File: logic/tile_rom.sv
`timescale 1ns/1ns

module tile_rom (
	input  logic                         clk,
	input  logic [video_pkg::ROM_AW-1:0] load_addr,
	input  logic [7:0]                   load_data,
	input  logic                         load_wr,
	input  logic [video_pkg::ROM_AW-2:0] fetch_addr,
	output logic [15:0]                  fetch_data
);
	import video_pkg::*;

	localparam int WORDS = 2**(ROM_AW - 1);

	logic [15:0]       mem [WORDS];
	logic [ROM_AW-2:0] load_word;
	logic              load_hi;

	// Byte 0 of each row word is the low byte
	assign load_word = load_addr[ROM_AW-1:1];
	assign load_hi   = load_addr[0];

	always_ff @(posedge clk) begin
		if (load_wr) begin
			if (load_hi)
				mem[load_word][15:8] <= load_data;
			else
				mem[load_word][7:0] <= load_data;
		end
		fetch_data <= mem[fetch_addr];   // Registered read
	end

endmodule

// File: logic/video_pkg.sv
package video_pkg;

	// CPU bus
	localparam int CPU_AW = 9;
	localparam int CPU_DW = 8;

	// Raster and pixel widths
	localparam int CNT_W       = 7;
	localparam int TILE_CODE_W = 4;
	localparam int PAL_W       = 4;
	localparam int COL_W       = 2;
	localparam int RGB_W       = 4;

	// Tile ROM load port, byte address is {code, row, byte}
	localparam int ROM_AW = 8;

	// Tile fetch pipeline depth
	localparam int CHAR_LAT = 3;

	// Each CPU region is 64 bytes long
	localparam int REGION_AW = 6;
	localparam logic [CPU_AW-1:0] TILEMAP_BASE = 9'h000;
	localparam logic [CPU_AW-1:0] PAL_RG_BASE  = 9'h100;
	localparam logic [CPU_AW-1:0] PAL_B_BASE   = 9'h180;

	typedef enum logic [1:0] {
		REG_NONE,
		REG_TILEMAP,
		REG_PAL_RG,   // Red high nibble, green low nibble
		REG_PAL_B     // Blue in low nibble
	} bus_region_e;

	function automatic bus_region_e cpu_region(input logic [CPU_AW-1:0] addr);
		bus_region_e region;
		region = REG_NONE;
		if (addr[CPU_AW-1:REGION_AW] == TILEMAP_BASE[CPU_AW-1:REGION_AW])
			region = REG_TILEMAP;
		else if (addr[CPU_AW-1:REGION_AW] == PAL_RG_BASE[CPU_AW-1:REGION_AW])
			region = REG_PAL_RG;
		else if (addr[CPU_AW-1:REGION_AW] == PAL_B_BASE[CPU_AW-1:REGION_AW])
			region = REG_PAL_B;
		return region;
	endfunction

endpackage

// File: logic/video_timer.sv
`timescale 1ns/1ns

module video_timer #(
	parameter int H_TOTAL   = 64,
	parameter int H_VISIBLE = 48,
	parameter int V_TOTAL   = 40,
	parameter int V_VISIBLE = 32
) (
	input  logic                      clk,
	input  logic                      rst,
	output logic [video_pkg::CNT_W-1:0] h,
	output logic [video_pkg::CNT_W-1:0] v,
	output logic                      lhbl,
	output logic                      lvbl
);
	import video_pkg::*;

	logic [CNT_W-1:0] h_next;
	logic [CNT_W-1:0] v_next;
	logic             h_wrap;
	logic             v_wrap;

	assign h_wrap = (h == CNT_W'(H_TOTAL - 1));
	assign v_wrap = (v == CNT_W'(V_TOTAL - 1));

	// Next raster position
	always_comb begin
		h_next = h_wrap ? '0 : h + 1'b1;
		v_next = v;
		if (h_wrap) begin
			v_next = v_wrap ? '0 : v + 1'b1;
		end
	end

	// Flags are computed from the next count so they line up with h and v
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			h    <= '0;
			v    <= '0;
			lhbl <= 1'b1;   // Position 0,0 is visible
			lvbl <= 1'b1;
		end else begin
			h    <= h_next;
			v    <= v_next;
			lhbl <= (h_next < CNT_W'(H_VISIBLE));
			lvbl <= (v_next < CNT_W'(V_VISIBLE));
		end
	end

endmodule

// File: include/tb_helpers.svh
`ifndef TB_HELPERS_SVH
`define TB_HELPERS_SVH

// One CPU bus write, mirrored into the reference memories by address range
task automatic bus_write(input logic [CPU_AW-1:0] addr, input logic [CPU_DW-1:0] data);
	cpu_addr = addr;
	cpu_dout = data;
	cpu_we   = 1'b1;
	step();
	cpu_we   = 1'b0;
	if (addr < 9'h040) begin
		map_ref[addr[5:0]] = data;
	end else if (addr >= 9'h100 && addr < 9'h140) begin
		pal_rg_ref[addr[5:0]] = data;
	end else if (addr >= 9'h180 && addr < 9'h1c0) begin
		pal_b_ref[addr[5:0]] = data[3:0];   // Blue only
	end
endtask

task automatic rom_load(input logic [ROM_AW-1:0] addr, input logic [7:0] data);
	romload_addr = addr;
	romload_data = data;
	romload_wr   = 1'b1;
	step();
	romload_wr   = 1'b0;
	rom_ref[addr] = data;
endtask

// Color of visible pixel x, y as {red, green, blue}
function automatic logic [11:0] expected_rgb(input int x, input int y);
	logic [7:0]  xb;
	logic [7:0]  yb;
	logic [7:0]  tile;
	logic [6:0]  word_idx;
	logic [15:0] word;
	logic [1:0]  pix;
	logic [5:0]  pidx;
	xb       = 8'(x);
	yb       = 8'(y);
	tile     = map_ref[{yb[5:3], xb[5:3]}];
	word_idx = {tile[7:4], yb[2:0]};   // Code and row
	word     = {rom_ref[{word_idx, 1'b1}], rom_ref[{word_idx, 1'b0}]};
	pix      = 2'(word >> {xb[2:0], 1'b0});
	pidx     = {tile[3:0], pix};
	return {pal_rg_ref[pidx], pal_b_ref[pidx]};
endfunction

task automatic check_rgb(input int x, input int y, input logic [11:0] want);
	logic [11:0] got;
	got = {red, green, blue};
	assert (got === want) else begin
		$display("CHECK FAILED at %0t: pixel x=%0d y=%0d expected rgb %03h, got %03h",
			$time, x, y, want, got);
		abort_run();
	end
endtask

task automatic check_count(input string what, input int got, input int want);
	assert (got == want) else begin
		$display("CHECK FAILED at %0t: %s is %0d, expected %0d", $time, what, got, want);
		abort_run();
	end
endtask

`endif

// File: tb/tb_game_video.sv
`timescale 1ns/1ns

module tb_game_video;
	import video_pkg::*;

	localparam int H_TOTAL       = 64;
	localparam int H_VISIBLE     = 48;
	localparam int V_TOTAL       = 40;
	localparam int V_VISIBLE     = 32;
	localparam int DRV           = 2;   // Drive delay after the rising edge
	localparam int FRAME_TIMEOUT = 2 * H_TOTAL * V_TOTAL;

	logic              clk;
	logic              rst;
	logic              downloading;
	logic [CPU_AW-1:0] cpu_addr;
	logic [CPU_DW-1:0] cpu_dout;
	logic              cpu_we;
	logic [ROM_AW-1:0] romload_addr;
	logic [7:0]        romload_data;
	logic              romload_wr;
	logic [RGB_W-1:0]  red;
	logic [RGB_W-1:0]  green;
	logic [RGB_W-1:0]  blue;
	logic              lhbl;
	logic              lvbl;

	// Reference copies of the DUT memories
	logic [7:0] map_ref    [64];
	logic [7:0] rom_ref    [256];
	logic [7:0] pal_rg_ref [64];
	logic [3:0] pal_b_ref  [64];

	logic        hbl_q;   // Blanking at the previous sample
	logic        vbl_q;
	logic [31:0] rng;

	game_video #(
		.H_TOTAL   ( H_TOTAL   ),
		.H_VISIBLE ( H_VISIBLE ),
		.V_TOTAL   ( V_TOTAL   ),
		.V_VISIBLE ( V_VISIBLE )
	) dut (
		.clk          ( clk          ),
		.rst          ( rst          ),
		.downloading  ( downloading  ),
		.cpu_addr     ( cpu_addr     ),
		.cpu_dout     ( cpu_dout     ),
		.cpu_we       ( cpu_we       ),
		.romload_addr ( romload_addr ),
		.romload_data ( romload_data ),
		.romload_wr   ( romload_wr   ),
		.red          ( red          ),
		.green        ( green        ),
		.blue         ( blue         ),
		.lhbl         ( lhbl         ),
		.lvbl         ( lvbl         )
	);

	always #10 clk = ~clk;

	task automatic abort_run();
		$display("Simulation FAILED");
		$fatal(1, "run stopped at the first error");
	endtask

	// Outputs are sampled at the drive time, well after the edge
	task automatic step();
		hbl_q = lhbl;
		vbl_q = lvbl;
		@(posedge clk);
		#DRV;
	endtask

	`include "tb_helpers.svh"

	function automatic logic [31:0] lcg_next(input logic [31:0] s);
		return s * 32'd1664525 + 32'd1013904223;
	endfunction

	task automatic wait_lvbl(input logic level);
		int n;
		n = 0;
		while (!(lvbl == level && vbl_q != level)) begin
			step();
			n++;
			if (n > FRAME_TIMEOUT) begin
				$display("Timeout waiting for an lvbl edge at time %0t", $time);
				abort_run();
			end
		end
	endtask

	// Position 0,0 is held through reset and leaves the pipeline first
	task automatic check_reset_state();
		int n;
		n = 0;
		while (!lhbl) begin
			assert (!lvbl && {red, green, blue} == 12'h000) else begin
				$display("CHECK FAILED at %0t: video active before first visible pixel", $time);
				abort_run();
			end
			step();
			n++;
			if (n > 16) begin
				$display("Timeout waiting for the first visible pixel after reset");
				abort_run();
			end
		end
		check_count("cycles to first visible pixel", n, CHAR_LAT + 1);
		check_count("lvbl at first visible pixel", int'(lvbl), 1);
	endtask

	// Starts on the first pixel of a frame, ends on the first pixel of the next
	task automatic frame_body();
		int c;
		int lines;
		int vis_lines;
		int x;
		logic [11:0] want;
		lines     = 0;
		vis_lines = 0;
		x         = 0;
		for (c = 0; c < H_TOTAL * V_TOTAL; c++) begin
			if (lhbl && !hbl_q) begin   // New line
				lines++;
				x = 0;
				if (lvbl) begin
					vis_lines++;
				end
			end
			if (!lhbl && hbl_q) begin
				check_count("lhbl high time", x, H_VISIBLE);
			end
			if (lhbl && lvbl && !downloading) begin
				want = expected_rgb(x, lines - 1);
			end else begin
				want = 12'h000;   // Blanked or muted
			end
			check_rgb(x, lines - 1, want);
			if (lhbl) begin
				x++;
			end
			step();
		end
		check_count("lvbl rise at frame end", int'(lvbl && !vbl_q), 1);
		check_count("lines per frame", lines, V_TOTAL);
		check_count("lines with lvbl high", vis_lines, V_VISIBLE);
	endtask

	task automatic check_frames(input int n);
		int f;
		wait_lvbl(1'b0);   // Earlier writes land before the frame fetches
		wait_lvbl(1'b1);
		for (f = 0; f < n; f++) begin
			frame_body();
		end
	endtask

	task automatic random_palette_writes(input int n);
		int i;
		logic [CPU_AW-1:0] addr;
		for (i = 0; i < n; i++) begin
			rng  = lcg_next(rng);
			addr = rng[12] ? {3'b100, rng[21:16]} : {3'b110, rng[21:16]};
			bus_write(addr, rng[31:24]);
		end
	endtask

	task automatic fill_memories();
		int i;
		logic [5:0] idx;
		for (i = 0; i < 256; i++) begin
			rom_load(8'(i), 8'(i * 113) ^ 8'h5a);
		end
		for (i = 0; i < 64; i++) begin
			idx = 6'(i);
			bus_write({3'b100, idx}, 8'(i * 37 + 19));
			bus_write({3'b110, idx}, {4'h0, idx[3:0] ^ {idx[5:4], idx[5:4]}});
		end
	endtask

	task automatic skip_line(input int fd);
		int c;
		c = 0;
		while (c != "\n" && c != -1) begin
			c = $fgetc(fd);
		end
	endtask

	task automatic expect_fields(input int got, input int want);
		if (got != want) begin
			$display("Malformed line in stimulus file");
			abort_run();
		end
	endtask

	task automatic run_stimulus();
		int fd;
		int n;
		int a;
		int d;
		logic [7:0] cmd;
		fd = $fopen("tb/video_stimulus.txt", "r");
		if (fd == 0) begin
			$display("Cannot open stimulus file tb/video_stimulus.txt");
			abort_run();
		end
		while ($fscanf(fd, " %c", cmd) == 1) begin
			case (cmd)
				"#": skip_line(fd);
				"L", "W": begin
					n = $fscanf(fd, " %h %h", a, d);
					expect_fields(n, 2);
					if (cmd == "L") begin
						rom_load(8'(a), 8'(d));
					end else begin
						bus_write(9'(a), 8'(d));
					end
				end
				"D", "F", "R": begin
					n = $fscanf(fd, " %d", a);
					expect_fields(n, 1);
					if (cmd == "D") begin
						downloading = (a != 0);
					end else if (cmd == "F") begin
						check_frames(a);
					end else begin
						random_palette_writes(a);
					end
				end
				default: begin
					$display("Unknown command %c in stimulus file", cmd);
					abort_run();
				end
			endcase
		end
		$fclose(fd);
	endtask

	initial begin
		clk          = 1'b0;
		rst          = 1'b1;
		downloading  = 1'b0;
		cpu_addr     = '0;
		cpu_dout     = '0;
		cpu_we       = 1'b0;
		romload_addr = '0;
		romload_data = '0;
		romload_wr   = 1'b0;
		hbl_q        = 1'b0;
		vbl_q        = 1'b0;
		rng          = 32'd42901;
		repeat (2) @(posedge clk);
		#DRV;
		rst = 1'b0;
		check_reset_state();
		fill_memories();
		run_stimulus();
		$display("Simulation PASSED");
		$finish;
	end

endmodule

// File: tb/video_stimulus.txt
# L addr data loads a tile ROM byte, W addr data is a CPU write (hex)
# D level sets downloading, F n checks n frames, R n makes n random palette writes
L 00 e4
L 01 1b
L f7 c3
W 000 03
W 001 1a
W 002 25
W 003 3c
W 004 47
W 005 51
W 008 6e
W 009 72
W 00a 89
W 00b 90
W 00c ab
W 00d b4
W 010 c6
W 011 df
W 012 e8
W 013 f2
W 014 0d
W 015 53
W 018 a0
W 019 37
W 01a fc
W 01b 19
W 01c 6b
W 01d e5
W 102 f0
W 182 0a
W 1bf 07
F 2
R 16
F 1
R 8
W 13a 5c
W 1a5 0e
F 1
# Move tiles and reload some graphics rows
W 000 f4
W 00d 08
W 01a 2e
L 20 ff
L 21 00
L 9e 3c
L 9f a5
F 1
D 1
F 1
D 0
F 1
